/* hdl/trap_consts.svh */
`ifndef TRAP_CONSTS_SVH
`define TRAP_CONSTS_SVH

// Machine data width
`define TRAP_XLEN 32

// AXI4-Lite byte address width
// CSR number sits in bits 13:2
`define TRAP_AXI_ADDR_W 14

// Writable mstatus bits, MIE at 3 and MPIE at 7
`define TRAP_MSTATUS_MASK 32'h0000_0088

// Implemented machine interrupt enables
`define TRAP_MIE_MASK 32'h0000_0888

// Interrupt bit positions in mie and mip
`define TRAP_BIT_MSI 3
`define TRAP_BIT_MTI 7
`define TRAP_BIT_MEI 11

`endif

/* hdl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  // Implemented CSR numbers
  // Counters live in the read-only 0xC00 block
  typedef enum logic [11:0] {
    csr_mstatus  = 12'h300,
    csr_mie      = 12'h304,
    csr_mtvec    = 12'h305,
    csr_mscratch = 12'h340,
    csr_mepc     = 12'h341,
    csr_mcause   = 12'h342,
    csr_mtval    = 12'h343,
    csr_mip      = 12'h344,
    csr_cycle    = 12'hC00,
    csr_time     = 12'hC01,
    csr_instret  = 12'hC02,
    csr_cycleh   = 12'hC80,
    csr_timeh    = 12'hC81,
    csr_instreth = 12'hC82
  } csr_num_e;

  // One bit per direction
  typedef enum logic [1:0] {
    op_none  = 2'b00,
    op_read  = 2'b01,
    op_write = 2'b10
  } csr_op_e;

  // Bus port FSM
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_wresp = 2'd1,
    st_rresp = 2'd2
  } axil_state_e;

endpackage : csr_pkg

`default_nettype wire

/* hdl/trap_pkg.sv */
`default_nettype none

package trap_pkg;

  // Synchronous exception codes reported by the pipeline
  typedef enum logic [3:0] {
    exc_instr_misaligned = 4'd0,
    exc_illegal          = 4'd2,
    exc_breakpoint       = 4'd3,
    exc_load_misaligned  = 4'd4,
    exc_store_misaligned = 4'd6,
    exc_ecall_m          = 4'd11
  } exc_cause_e;

  // Machine interrupt codes, equal to their mip bit
  typedef enum logic [3:0] {
    irq_msi = 4'd3,
    irq_mti = 4'd7,
    irq_mei = 4'd11
  } irq_cause_e;

  // Event handed from the trap unit to the CSR file
  typedef enum logic [1:0] {
    ev_none      = 2'd0,
    ev_exception = 2'd1,
    ev_interrupt = 2'd2,
    ev_mret      = 2'd3
  } trap_event_e;

endpackage : trap_pkg

`default_nettype wire

/* hdl/csr_axil_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "trap_consts.svh"

module csr_axil_port (
  input  logic                        i_clk,
  input  logic                        i_rst,
  // Write address and data channels
  output logic                        o_awready,
  input  logic                        i_awvalid,
  input  logic [`TRAP_AXI_ADDR_W-1:0] i_awaddr,
  input  logic                        i_wvalid,
  input  logic [`TRAP_XLEN-1:0]       i_wdata,
  input  logic [`TRAP_XLEN/8-1:0]     i_wstrb,
  output logic                        o_wready,
  // Write response channel
  output logic                        o_bvalid,
  input  logic                        i_bready,
  output logic [1:0]                  o_bresp,
  // Read channels
  input  logic                        i_arvalid,
  input  logic [`TRAP_AXI_ADDR_W-1:0] i_araddr,
  output logic                        o_arready,
  output logic                        o_rvalid,
  input  logic                        i_rready,
  output logic [`TRAP_XLEN-1:0]       o_rdata,
  output logic [1:0]                  o_rresp,
  // Single-cycle CSR access
  output csr_pkg::csr_op_e            o_csr_op,
  output csr_pkg::csr_num_e           o_csr_num,
  output logic [`TRAP_XLEN-1:0]       o_csr_wdata,
  input  logic [`TRAP_XLEN-1:0]       i_csr_rdata,
  input  logic                        i_csr_err
);
  import csr_pkg::*;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  axil_state_e           state;
  logic                  wr_go;
  logic                  rd_go;
  logic [1:0]            resp_q;
  logic [`TRAP_XLEN-1:0] rdata_q;

  // Write needs both address and data in the same idle cycle
  assign wr_go = (state == st_idle) && i_awvalid && i_wvalid;
  // Read only when no write is ready
  assign rd_go = (state == st_idle) && i_arvalid && !wr_go;

  assign o_awready = wr_go;
  assign o_wready  = wr_go;
  assign o_arready = rd_go;

  always_comb begin
    if (wr_go) begin
      o_csr_op = op_write;
    end else if (rd_go) begin
      o_csr_op = op_read;
    end else begin
      o_csr_op = op_none;
    end
  end

  // Word address selects the CSR
  assign o_csr_num = csr_num_e'(wr_go ? i_awaddr[`TRAP_AXI_ADDR_W-1:2]
                                      : i_araddr[`TRAP_AXI_ADDR_W-1:2]);

  // Unstrobed bytes keep the current register value
  always_comb begin
    for (int b = 0; b < `TRAP_XLEN/8; b++) begin
      o_csr_wdata[8*b +: 8] = i_wstrb[b] ? i_wdata[8*b +: 8] : i_csr_rdata[8*b +: 8];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (wr_go) begin
            state <= st_wresp;
          end else if (rd_go) begin
            state <= st_rresp;
          end
        end
        // Response held until the master takes it
        st_wresp: if (i_bready) state <= st_idle;
        st_rresp: if (i_rready) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // Response captured at the access edge and stable until handshake
  always_ff @(posedge i_clk) begin
    if (wr_go || rd_go) begin
      resp_q <= i_csr_err ? resp_slverr : resp_okay;
    end
    if (rd_go) begin
      rdata_q <= i_csr_err ? '0 : i_csr_rdata;
    end
  end

  assign o_bvalid = (state == st_wresp);
  assign o_rvalid = (state == st_rresp);
  assign o_bresp  = resp_q;
  assign o_rresp  = resp_q;
  assign o_rdata  = rdata_q;

endmodule : csr_axil_port

`default_nettype wire

/* hdl/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "trap_consts.svh"

module csr_file (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // Bus access
  input  csr_pkg::csr_op_e      i_csr_op,
  input  csr_pkg::csr_num_e     i_csr_num,
  input  logic [`TRAP_XLEN-1:0] i_csr_wdata,
  output logic [`TRAP_XLEN-1:0] o_csr_rdata,
  output logic                  o_csr_err,
  // Trap entry and exit
  input  trap_pkg::trap_event_e i_trap_event,
  input  logic [`TRAP_XLEN-1:0] i_trap_cause,
  input  logic [`TRAP_XLEN-1:0] i_trap_epc,
  input  logic [`TRAP_XLEN-1:0] i_trap_tval,
  // Counter and interrupt sources
  input  logic                  i_retire,
  input  logic [63:0]           i_mtime,
  input  logic                  i_irq_sw,
  input  logic                  i_irq_timer,
  input  logic                  i_irq_ext,
  // State for the trap unit
  output logic                  o_mstatus_mie,
  output logic [`TRAP_XLEN-1:0] o_mie,
  output logic [`TRAP_XLEN-1:0] o_mip,
  output logic [`TRAP_XLEN-1:0] o_mtvec,
  output logic [`TRAP_XLEN-1:0] o_mepc
);
  import csr_pkg::*;
  import trap_pkg::*;

  localparam int xlen     = `TRAP_XLEN;
  localparam int mie_pos  = 3;
  localparam int mpie_pos = 7;

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mie;
  logic [xlen-1:0] mip;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mscratch;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] mtval;
  logic [63:0]     cycle;
  logic [63:0]     instret;
  logic [xlen-1:0] irq_vec;
  logic            implemented;
  logic            read_only;
  logic            wr_en;

  // Interrupt lines placed at their mip positions
  always_comb begin
    irq_vec = '0;
    irq_vec[`TRAP_BIT_MSI] = i_irq_sw;
    irq_vec[`TRAP_BIT_MTI] = i_irq_timer;
    irq_vec[`TRAP_BIT_MEI] = i_irq_ext;
  end

  // Read mux returns zero for unknown numbers
  always_comb begin
    o_csr_rdata = '0;
    implemented = 1'b1;
    case (i_csr_num)
      csr_mstatus:  o_csr_rdata = mstatus;
      csr_mie:      o_csr_rdata = mie;
      csr_mtvec:    o_csr_rdata = mtvec;
      csr_mscratch: o_csr_rdata = mscratch;
      csr_mepc:     o_csr_rdata = mepc;
      csr_mcause:   o_csr_rdata = mcause;
      csr_mtval:    o_csr_rdata = mtval;
      csr_mip:      o_csr_rdata = mip;
      csr_cycle:    o_csr_rdata = cycle[31:0];
      csr_time:     o_csr_rdata = i_mtime[31:0];
      csr_instret:  o_csr_rdata = instret[31:0];
      csr_cycleh:   o_csr_rdata = cycle[63:32];
      csr_timeh:    o_csr_rdata = i_mtime[63:32];
      csr_instreth: o_csr_rdata = instret[63:32];
      default:      implemented = 1'b0;
    endcase
  end

  // mip and the 0xC00 block are read-only
  assign read_only = (i_csr_num == csr_mip) || (i_csr_num[11:10] == 2'b11);
  assign o_csr_err = !implemented || (read_only && (i_csr_op == op_write));
  assign wr_en     = (i_csr_op == op_write) && !o_csr_err;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mstatus  <= '0;
      mie      <= '0;
      mip      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      cycle    <= '0;
      instret  <= '0;
    end else begin
      // One cycle of sampling delay on the lines
      mip   <= irq_vec;
      cycle <= cycle + 64'd1;
      if (i_retire) begin
        instret <= instret + 64'd1;
      end
      if (wr_en) begin
        case (i_csr_num)
          csr_mstatus:  mstatus <= i_csr_wdata & `TRAP_MSTATUS_MASK;
          csr_mie:      mie <= i_csr_wdata & `TRAP_MIE_MASK;
          // Modes 0 and 1 only
          csr_mtvec:    mtvec <= {i_csr_wdata[xlen-1:2], 1'b0, i_csr_wdata[0]};
          csr_mscratch: mscratch <= i_csr_wdata;
          csr_mepc:     mepc <= {i_csr_wdata[xlen-1:1], 1'b0};
          csr_mcause:   mcause <= i_csr_wdata;
          csr_mtval:    mtval <= i_csr_wdata;
          default:      ;
        endcase
      end
      // Trap updates come last and override a same-cycle bus write
      if ((i_trap_event == ev_exception) || (i_trap_event == ev_interrupt)) begin
        mepc              <= {i_trap_epc[xlen-1:1], 1'b0};
        mcause            <= i_trap_cause;
        mtval             <= i_trap_tval;
        mstatus[mpie_pos] <= mstatus[mie_pos];
        mstatus[mie_pos]  <= 1'b0;
      end else if (i_trap_event == ev_mret) begin
        mstatus[mie_pos]  <= mstatus[mpie_pos];
        mstatus[mpie_pos] <= 1'b1;
      end
    end
  end

  assign o_mstatus_mie = mstatus[mie_pos];
  assign o_mie         = mie;
  assign o_mip         = mip;
  assign o_mtvec       = mtvec;
  assign o_mepc        = mepc;

  // Port parks in a response state after every access
  a_no_back_to_back: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_csr_op != op_none) |=> (i_csr_op == op_none));

endmodule : csr_file

`default_nettype wire

/* hdl/trap_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "trap_consts.svh"

module trap_unit (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // Pipeline events
  input  logic                  i_exc_valid,
  input  trap_pkg::exc_cause_e  i_exc_cause,
  input  logic [`TRAP_XLEN-1:0] i_exc_tval,
  input  logic [`TRAP_XLEN-1:0] i_trap_pc,
  input  logic                  i_mret,
  input  logic                  i_wfi,
  // CSR state
  input  logic                  i_mstatus_mie,
  input  logic [`TRAP_XLEN-1:0] i_mie,
  input  logic [`TRAP_XLEN-1:0] i_mip,
  input  logic [`TRAP_XLEN-1:0] i_mtvec,
  input  logic [`TRAP_XLEN-1:0] i_mepc,
  // To the CSR file
  output trap_pkg::trap_event_e o_trap_event,
  output logic [`TRAP_XLEN-1:0] o_trap_cause,
  output logic [`TRAP_XLEN-1:0] o_trap_epc,
  output logic [`TRAP_XLEN-1:0] o_trap_tval,
  // To the pipeline
  output logic                  o_redirect_valid,
  output logic [`TRAP_XLEN-1:0] o_redirect_pc,
  output logic                  o_wfi_stall
);
  import trap_pkg::*;

  localparam int xlen = `TRAP_XLEN;

  logic [xlen-1:0] pending;
  logic            irq_take;
  irq_cause_e      irq_cause;
  logic [xlen-1:0] base;
  logic [xlen-1:0] target;

  // Pending and enabled, implemented lines only
  assign pending = i_mie & i_mip & `TRAP_MIE_MASK;

  // No interrupt while a redirect is in flight
  // Reported PC then belongs to a flushed instruction
  assign irq_take = i_mstatus_mie && (|pending) && !o_redirect_valid;

  // MEI over MSI over MTI
  always_comb begin
    if (pending[`TRAP_BIT_MEI]) begin
      irq_cause = irq_mei;
    end else if (pending[`TRAP_BIT_MSI]) begin
      irq_cause = irq_msi;
    end else begin
      irq_cause = irq_mti;
    end
  end

  assign base = {i_mtvec[xlen-1:2], 2'b00};

  // Exception over MRET over interrupt
  always_comb begin
    o_trap_event = ev_none;
    o_trap_cause = '0;
    o_trap_tval  = '0;
    target       = base;
    if (i_exc_valid) begin
      o_trap_event = ev_exception;
      o_trap_cause = {{(xlen-4){1'b0}}, i_exc_cause};
      o_trap_tval  = i_exc_tval;
    end else if (i_mret) begin
      o_trap_event = ev_mret;
      target       = i_mepc;
    end else if (irq_take) begin
      o_trap_event = ev_interrupt;
      o_trap_cause = {1'b1, {(xlen-5){1'b0}}, irq_cause};
      // Vectored mode jumps to base + 4 * cause
      if (i_mtvec[0]) begin
        target = base + {{(xlen-6){1'b0}}, irq_cause, 2'b00};
      end
    end
  end

  assign o_trap_epc = i_trap_pc;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_redirect_valid <= 1'b0;
    end else begin
      o_redirect_valid <= (o_trap_event != ev_none);
    end
  end

  always_ff @(posedge i_clk) begin
    o_redirect_pc <= target;
  end

  // Stall until any enabled interrupt is pending, regardless of MIE
  assign o_wfi_stall = i_wfi && !(|(i_mip & i_mie));

  // Pipeline flushes on redirect, so events arrive as single pulses
  a_redirect_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
    o_redirect_valid |=> !o_redirect_valid);

endmodule : trap_unit

`default_nettype wire

/* hdl/trap_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "trap_consts.svh"

module trap_ctrl_top (
  input  logic                        i_clk,
  input  logic                        i_rst,
  // AXI4-Lite slave
  output logic                        o_awready,
  input  logic                        i_awvalid,
  input  logic [`TRAP_AXI_ADDR_W-1:0] i_awaddr,
  input  logic                        i_wvalid,
  input  logic [`TRAP_XLEN-1:0]       i_wdata,
  input  logic [`TRAP_XLEN/8-1:0]     i_wstrb,
  output logic                        o_wready,
  output logic                        o_bvalid,
  input  logic                        i_bready,
  output logic [1:0]                  o_bresp,
  input  logic                        i_arvalid,
  input  logic [`TRAP_AXI_ADDR_W-1:0] i_araddr,
  output logic                        o_arready,
  output logic                        o_rvalid,
  input  logic                        i_rready,
  output logic [`TRAP_XLEN-1:0]       o_rdata,
  output logic [1:0]                  o_rresp,
  // Pipeline events
  input  logic                        i_exc_valid,
  input  trap_pkg::exc_cause_e        i_exc_cause,
  input  logic [`TRAP_XLEN-1:0]       i_exc_tval,
  input  logic [`TRAP_XLEN-1:0]       i_trap_pc,
  input  logic                        i_mret,
  input  logic                        i_wfi,
  input  logic                        i_retire,
  // Interrupt lines and timer
  input  logic                        i_irq_sw,
  input  logic                        i_irq_timer,
  input  logic                        i_irq_ext,
  input  logic [63:0]                 i_mtime,
  // PC control
  output logic                        o_redirect_valid,
  output logic [`TRAP_XLEN-1:0]       o_redirect_pc,
  output logic                        o_wfi_stall
);
  import csr_pkg::*;
  import trap_pkg::*;

  // Port to CSR file
  csr_op_e               csr_op;
  csr_num_e              csr_num;
  logic [`TRAP_XLEN-1:0] csr_wdata;
  logic [`TRAP_XLEN-1:0] csr_rdata;
  logic                  csr_err;
  // Trap unit to CSR file
  trap_event_e           trap_event;
  logic [`TRAP_XLEN-1:0] trap_cause;
  logic [`TRAP_XLEN-1:0] trap_epc;
  logic [`TRAP_XLEN-1:0] trap_tval;
  // CSR file to trap unit
  logic                  mstatus_mie;
  logic [`TRAP_XLEN-1:0] mie;
  logic [`TRAP_XLEN-1:0] mip;
  logic [`TRAP_XLEN-1:0] mtvec;
  logic [`TRAP_XLEN-1:0] mepc;

  csr_axil_port csr_axil_port_inst (
    .i_clk,
    .i_rst,
    .o_awready,
    .i_awvalid,
    .i_awaddr,
    .i_wvalid,
    .i_wdata,
    .i_wstrb,
    .o_wready,
    .o_bvalid,
    .i_bready,
    .o_bresp,
    .i_arvalid,
    .i_araddr,
    .o_arready,
    .o_rvalid,
    .i_rready,
    .o_rdata,
    .o_rresp,
    .o_csr_op(csr_op),
    .o_csr_num(csr_num),
    .o_csr_wdata(csr_wdata),
    .i_csr_rdata(csr_rdata),
    .i_csr_err(csr_err)
  );

  csr_file csr_file_inst (
    .i_clk,
    .i_rst,
    .i_csr_op(csr_op),
    .i_csr_num(csr_num),
    .i_csr_wdata(csr_wdata),
    .o_csr_rdata(csr_rdata),
    .o_csr_err(csr_err),
    .i_trap_event(trap_event),
    .i_trap_cause(trap_cause),
    .i_trap_epc(trap_epc),
    .i_trap_tval(trap_tval),
    .i_retire,
    .i_mtime,
    .i_irq_sw,
    .i_irq_timer,
    .i_irq_ext,
    .o_mstatus_mie(mstatus_mie),
    .o_mie(mie),
    .o_mip(mip),
    .o_mtvec(mtvec),
    .o_mepc(mepc)
  );

  trap_unit trap_unit_inst (
    .i_clk,
    .i_rst,
    .i_exc_valid,
    .i_exc_cause,
    .i_exc_tval,
    .i_trap_pc,
    .i_mret,
    .i_wfi,
    .i_mstatus_mie(mstatus_mie),
    .i_mie(mie),
    .i_mip(mip),
    .i_mtvec(mtvec),
    .i_mepc(mepc),
    .o_trap_event(trap_event),
    .o_trap_cause(trap_cause),
    .o_trap_epc(trap_epc),
    .o_trap_tval(trap_tval),
    .o_redirect_valid,
    .o_redirect_pc,
    .o_wfi_stall
  );

endmodule : trap_ctrl_top

`default_nettype wire

/* verif/trap_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "trap_consts.svh"

module trap_ctrl_tb;
  import csr_pkg::*;
  import trap_pkg::*;

  localparam int aw = `TRAP_AXI_ADDR_W;
  localparam int xlen = `TRAP_XLEN;
  // Limit is twice the summed test length of about 1500 cycles
  localparam int test_cycles = 1500;
  localparam int max_cycles = 2 * test_cycles;
  localparam logic [1:0] okay = 2'b00;
  localparam logic [1:0] slverr = 2'b10;

  logic             clk = 1'b0;
  logic             rst;
  logic             awready, awvalid, wvalid, wready, bvalid, bready;
  logic [aw-1:0]    awaddr, araddr;
  logic [xlen-1:0]  wdata, rdata;
  logic [3:0]       wstrb;
  logic [1:0]       bresp, rresp;
  logic             arvalid, arready, rvalid, rready;
  logic             exc_valid, mret, wfi, retire;
  exc_cause_e       exc_cause;
  logic [xlen-1:0]  exc_tval, trap_pc;
  logic             irq_sw, irq_timer, irq_ext;
  logic [63:0]      mtime;
  logic             redirect_valid, wfi_stall;
  logic [xlen-1:0]  redirect_pc;
  integer           seed = 32'hbd26_7595;
  int               errors = 0;
  int               checks = 0;
  int               cycles = 0;

  trap_ctrl_top u_dut (
    .i_clk(clk), .i_rst(rst),
    .o_awready(awready), .i_awvalid(awvalid), .i_awaddr(awaddr),
    .i_wvalid(wvalid), .i_wdata(wdata), .i_wstrb(wstrb), .o_wready(wready),
    .o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
    .i_arvalid(arvalid), .i_araddr(araddr), .o_arready(arready),
    .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp),
    .i_exc_valid(exc_valid), .i_exc_cause(exc_cause), .i_exc_tval(exc_tval),
    .i_trap_pc(trap_pc), .i_mret(mret), .i_wfi(wfi), .i_retire(retire),
    .i_irq_sw(irq_sw), .i_irq_timer(irq_timer), .i_irq_ext(irq_ext),
    .i_mtime(mtime),
    .o_redirect_valid(redirect_valid), .o_redirect_pc(redirect_pc),
    .o_wfi_stall(wfi_stall)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Redirect is a single-cycle pulse
  a_redirect_pulse: assert property (@(posedge clk) disable iff (rst)
    redirect_valid |=> !redirect_valid)
    else begin
      errors++;
      $display("redirect stayed high for two cycles");
    end

  // Exception or MRET sampled at edge N gives a redirect in cycle N+1
  a_event_redirect: assert property (@(posedge clk) disable iff (rst)
    (exc_valid || mret) |=> redirect_valid)
    else begin
      errors++;
      $display("no redirect in the cycle after an exception or MRET");
    end

  // Only OKAY and SLVERR are ever returned
  a_resp_code: assert property (@(posedge clk) disable iff (rst)
    (bvalid |-> (bresp == okay || bresp == slverr)) and
    (rvalid |-> (rresp == okay || rresp == slverr)))
    else begin
      errors++;
      $display("response code is neither OKAY nor SLVERR");
    end

  // mip is read-only
  a_mip_write_err: assert property (@(posedge clk) disable iff (rst)
    (awready && awaddr[aw-1:2] == 12'h344) |=> (bvalid && bresp == slverr))
    else begin
      errors++;
      $display("write to mip did not return SLVERR");
    end

  // Read response held stable under back-pressure
  a_rresp_hold: assert property (@(posedge clk) disable iff (rst)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else begin
      errors++;
      $display("read response changed while the master stalled");
    end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // AXI master write that returns BRESP
  task automatic axi_write(input logic [11:0] num, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    awvalid = 1'b1;
    awaddr  = {num, 2'b00};
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    bready  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  // AXI master read that holds RREADY low for one cycle
  task automatic axi_read(input logic [11:0] num, output logic [31:0] data,
                          output logic [1:0] resp);
    arvalid = 1'b1;
    araddr  = {num, 2'b00};
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic csr_write(input logic [11:0] num, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(num, data, 4'hf, resp);
    check_eq($sformatf("bresp csr_%h", num), resp, okay);
  endtask

  task automatic csr_expect(input logic [11:0] num, input logic [31:0] exp);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(num, data, resp);
    check_eq($sformatf("rresp csr_%h", num), resp, okay);
    check_eq($sformatf("rdata csr_%h", num), data, exp);
  endtask

  // One-cycle pipeline event that returns one step after the sampling edge
  task automatic pipe_event(input logic exc, input exc_cause_e cause, input logic [31:0] tval,
                            input logic [31:0] pc, input logic is_mret);
    exc_valid = exc;
    exc_cause = cause;
    exc_tval  = tval;
    trap_pc   = pc;
    mret      = is_mret;
    @(posedge clk);
    #1;
    exc_valid = 1'b0;
    mret      = 1'b0;
  endtask

  task automatic expect_redirect(input logic [31:0] exp_pc);
    check_eq("o_redirect_valid", redirect_valid, 1);
    check_eq("o_redirect_pc", redirect_pc, exp_pc);
  endtask

  // Interrupts arrive after the mip sampling delay
  task automatic wait_redirect(input int limit, input logic [31:0] exp_pc);
    int n;
    n = 0;
    while (!redirect_valid && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    assert (redirect_valid) else begin
      errors++;
      $display("no interrupt redirect within %0d cycles", limit);
    end
    if (redirect_valid) begin
      check_eq("o_redirect_pc", redirect_pc, exp_pc);
    end
  endtask

  initial begin
    csr_num_e    zero_list [13];
    logic [31:0] r1, r2, pc, tval, c1, c2;
    logic [1:0]  resp;
    logic [31:0] data;
    int          err0;
    int          n;

    zero_list = '{csr_mstatus, csr_mie, csr_mtvec, csr_mscratch, csr_mepc, csr_mcause,
                  csr_mtval, csr_mip, csr_instret, csr_instreth, csr_cycleh, csr_time,
                  csr_timeh};
    rst = 1'b1;
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    wstrb = '0;
    {exc_valid, mret, wfi, retire, irq_sw, irq_timer, irq_ext} = '0;
    exc_cause = exc_instr_misaligned;
    exc_tval = '0;
    trap_pc = '0;
    mtime = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Reset state, bus access and error responses
    err0 = errors;
    check_eq("o_redirect_valid", redirect_valid, 0);
    check_eq("o_bvalid", bvalid, 0);
    check_eq("o_rvalid", rvalid, 0);
    check_eq("o_awready", awready, 0);
    check_eq("o_wready", wready, 0);
    check_eq("o_arready", arready, 0);
    foreach (zero_list[i]) begin
      csr_expect(zero_list[i], 32'h0);
    end
    r1 = $random(seed);
    csr_write(csr_mscratch, r1);
    csr_expect(csr_mscratch, r1);
    r2 = $random(seed);
    axi_write(csr_mscratch, r2, 4'b0101, resp);
    check_eq("bresp mscratch strobe", resp, okay);
    csr_expect(csr_mscratch, {r1[31:24], r2[23:16], r1[15:8], r2[7:0]});
    axi_write(12'h7c0, r1, 4'hf, resp);
    check_eq("bresp unimplemented", resp, slverr);
    axi_read(12'h7c0, data, resp);
    check_eq("rresp unimplemented", resp, slverr);
    check_eq("rdata unimplemented", data, 32'h0);
    axi_write(csr_mip, 32'hffff_ffff, 4'hf, resp);
    check_eq("bresp mip", resp, slverr);
    csr_expect(csr_mip, 32'h0);
    end_test("1 reset and access", err0);

    // Writable masks
    err0 = errors;
    csr_write(csr_mstatus, 32'hffff_ffff);
    // MIE at bit 3 and MPIE at bit 7 only
    csr_expect(csr_mstatus, 32'h0000_0088);
    csr_write(csr_mie, 32'hffff_ffff);
    // MSI, MTI and MEI enables at bits 3, 7 and 11
    csr_expect(csr_mie, 32'h0000_0888);
    csr_write(csr_mstatus, 32'h0);
    csr_write(csr_mie, 32'h0);
    end_test("2 masks", err0);

    // Exception entry with MIE set beforehand
    err0 = errors;
    csr_write(csr_mtvec, 32'h0000_1000);
    csr_write(csr_mstatus, 32'h0000_0008);
    pc = $random(seed);
    tval = $random(seed);
    pipe_event(1'b1, exc_illegal, tval, pc, 1'b0);
    expect_redirect(32'h0000_1000);
    csr_expect(csr_mepc, {pc[31:1], 1'b0});
    csr_expect(csr_mcause, 32'd2);
    csr_expect(csr_mtval, tval);
    // MPIE takes the old MIE and MIE is cleared
    csr_expect(csr_mstatus, 32'h0000_0080);
    end_test("3 exception", err0);

    // Vectored interrupt where MEI wins
    err0 = errors;
    csr_write(csr_mtvec, 32'h0000_2001);
    csr_write(csr_mie, 32'hffff_ffff);
    csr_write(csr_mstatus, 32'h0000_0008);
    pc = $random(seed);
    trap_pc = pc;
    irq_sw = 1'b1;
    irq_timer = 1'b1;
    irq_ext = 1'b1;
    wait_redirect(8, 32'h0000_2000 + 32'd44);
    csr_expect(csr_mcause, 32'h8000_000b);
    csr_expect(csr_mepc, {pc[31:1], 1'b0});
    // MIE now clear with the lines still high
    for (n = 0; n < 8; n++) begin
      @(posedge clk);
      #1;
      check_eq("o_redirect_valid with MIE clear", redirect_valid, 0);
    end
    {irq_sw, irq_timer, irq_ext} = '0;
    repeat (2) @(posedge clk);
    #1;
    wfi = 1'b1;
    #1;
    check_eq("o_wfi_stall idle", wfi_stall, 1);
    @(posedge clk);
    #1;
    irq_timer = 1'b1;
    n = 0;
    while (wfi_stall && n < 4) begin
      @(posedge clk);
      #1;
      n++;
    end
    check_eq("o_wfi_stall pending", wfi_stall, 0);
    wfi = 1'b0;
    irq_timer = 1'b0;
    csr_write(csr_mie, 32'h0);
    end_test("4 interrupt and wfi", err0);

    // MRET and then MRET against an exception
    err0 = errors;
    csr_write(csr_mepc, 32'h0000_3000);
    csr_write(csr_mstatus, 32'h0000_0080);
    pipe_event(1'b0, exc_instr_misaligned, 32'h0, 32'h0, 1'b1);
    expect_redirect(32'h0000_3000);
    csr_expect(csr_mstatus, 32'h0000_0088);
    pc = $random(seed);
    tval = $random(seed);
    pipe_event(1'b1, exc_ecall_m, tval, pc, 1'b1);
    expect_redirect(32'h0000_2000);
    csr_expect(csr_mcause, 32'd11);
    csr_expect(csr_mepc, {pc[31:1], 1'b0});
    csr_expect(csr_mstatus, 32'h0000_0080);
    end_test("5 mret", err0);

    // Counters
    err0 = errors;
    repeat (5) begin
      retire = 1'b1;
      @(posedge clk);
      #1;
      retire = 1'b0;
      @(posedge clk);
      #1;
    end
    csr_expect(csr_instret, 32'd5);
    csr_expect(csr_instreth, 32'd0);
    mtime = {$random(seed), $random(seed)};
    csr_expect(csr_time, mtime[31:0]);
    csr_expect(csr_timeh, mtime[63:32]);
    axi_read(csr_cycle, c1, resp);
    axi_read(csr_cycle, c2, resp);
    assert (c2 > c1) else begin
      errors++;
      $display("cycle counter did not increase between two reads");
    end
    end_test("6 counters", err0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : trap_ctrl_tb

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/csr_pkg.sv
hdl/trap_pkg.sv
hdl/csr_axil_port.sv
hdl/csr_file.sv
hdl/trap_unit.sv
hdl/trap_ctrl_top.sv
verif/trap_ctrl_tb.sv

/* Bender.yml */
package:
  name: trap_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/csr_pkg.sv
      - hdl/trap_pkg.sv
      - hdl/csr_axil_port.sv
      - hdl/csr_file.sv
      - hdl/trap_unit.sv
      - hdl/trap_ctrl_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/trap_ctrl_tb.sv
